// File: Makefile
VERILATOR ?= verilator
TOP       := tb_vec_unit
FILELIST  := build.f
VFLAGS    := --binary -j 0 -Wno-fatal --top-module $(TOP)
LOG       := sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qF '** PASS **' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: build.f
hdl/vec_pkg.sv
hdl/vec_dispatcher.sv
hdl/vec_sequencer.sv
hdl/vec_lane.sv
hdl/vec_scalar_result.sv
hdl/vec_unit.sv
dv/tb_vec_unit.sv

// File: dv/tb_vec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vec_unit;

  logic                clk_i = 1'b0;
  logic                rst_n_i;
  logic                req_valid_i;
  vec_pkg::vinsn_u     req_insn_i;
  vec_pkg::elem_t      req_scalar_i;
  logic                req_ready_o;
  logic                resp_valid_o;
  vec_pkg::elem_t      resp_data_o;

  // Reference state: full vector file and current vl
  vec_pkg::elem_t      model_vrf [vec_pkg::NR_VREGS][vec_pkg::VLMAX];
  int                  model_vl;
  vec_pkg::elem_t      resp_q[$];
  int                  errors;
  int                  n_sent;
  // Falling edges spent waiting on a low req_ready_o
  int                  stalls;

  always #5 clk_i = ~clk_i;

  vec_unit u_vec_unit (
    .clk_i        (clk_i       ),
    .rst_n_i      (rst_n_i     ),
    .req_valid_i  (req_valid_i ),
    .req_insn_i   (req_insn_i  ),
    .req_scalar_i (req_scalar_i),
    .req_ready_o  (req_ready_o ),
    .resp_valid_o (resp_valid_o),
    .resp_data_o  (resp_data_o )
  );

  // Responses collected mid-cycle, away from the clock edge
  always @(negedge clk_i) begin
    if (resp_valid_o) begin
      resp_q.push_back(resp_data_o);
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic check_eq(input vec_pkg::elem_t got, input vec_pkg::elem_t exp,
                          input string msg);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  function automatic vec_pkg::vinsn_u make_cfg();
    vec_pkg::vinsn_u w;
    w = '0;
    w.cfg.fmt = 1'b1;
    return w;
  endfunction

  function automatic vec_pkg::vinsn_u make_arith(input vec_pkg::vop_e op,
      input vec_pkg::vreg_idx_t vd, input vec_pkg::vreg_idx_t vs1,
      input vec_pkg::vreg_idx_t vs2, input logic use_scalar);
    vec_pkg::vinsn_u w;
    w = '0;
    w.arith.funct      = op;
    w.arith.vd         = vd;
    w.arith.vs1        = vs1;
    w.arith.vs2        = vs2;
    w.arith.use_scalar = use_scalar;
    return w;
  endfunction

  // Element rule: vd = vs2 op operand, move takes the operand
  function automatic vec_pkg::elem_t apply_op(input vec_pkg::vop_e op,
      input vec_pkg::elem_t a, input vec_pkg::elem_t b);
    case (op)
      vec_pkg::VOP_ADD: return a + b;
      vec_pkg::VOP_SUB: return a - b;
      vec_pkg::VOP_AND: return a & b;
      vec_pkg::VOP_OR:  return a | b;
      vec_pkg::VOP_XOR: return a ^ b;
      default:          return b;
    endcase
  endfunction

  // Ends on the accepting rising edge; hold keeps valid high for the next one
  task automatic send_insn(input vec_pkg::vinsn_u insn, input vec_pkg::elem_t scalar,
                           input logic hold);
    @(negedge clk_i);
    req_valid_i  = 1'b1;
    req_insn_i   = insn;
    req_scalar_i = scalar;
    while (!req_ready_o) begin
      stalls++;
      @(negedge clk_i);
    end
    @(posedge clk_i);
    n_sent++;
    if (!hold) begin
      @(negedge clk_i);
      req_valid_i = 1'b0;
    end
  endtask

  task automatic expect_resp(input vec_pkg::elem_t exp, input string msg);
    vec_pkg::elem_t got;
    while (resp_q.size() == 0) @(posedge clk_i);
    got = resp_q.pop_front();
    check_eq(got, exp, msg);
  endtask

  task automatic set_vl(input vec_pkg::elem_t req);
    model_vl = (req > vec_pkg::elem_t'(vec_pkg::VLMAX)) ? vec_pkg::VLMAX : int'(req);
    send_insn(make_cfg(), req, 1'b0);
    expect_resp(vec_pkg::elem_t'(model_vl), $sformatf("setvl %0d", req));
  endtask

  task automatic run_op(input vec_pkg::vop_e op, input vec_pkg::vreg_idx_t vd,
      input vec_pkg::vreg_idx_t vs1, input vec_pkg::vreg_idx_t vs2,
      input logic use_scalar, input vec_pkg::elem_t scalar, input logic hold);
    vec_pkg::elem_t opnd;
    int             i;
    send_insn(make_arith(op, vd, vs1, vs2, use_scalar), scalar, hold);
    for (i = 0; i < model_vl; i++) begin
      opnd = use_scalar ? scalar : model_vrf[vs1][i];
      model_vrf[vd][i] = apply_op(op, model_vrf[vs2][i], opnd);
    end
  endtask

  task automatic read_elem(input vec_pkg::vreg_idx_t r, input vec_pkg::elem_t idx);
    vec_pkg::elem_t exp;
    exp = (idx < vec_pkg::elem_t'(vec_pkg::VLMAX)) ? model_vrf[r][idx[3:0]] : '0;
    send_insn(make_arith(vec_pkg::VOP_EXTRACT, 3'd0, 3'd0, r, 1'b0), idx, 1'b0);
    expect_resp(exp, $sformatf("extract v%0d[%0d]", r, idx));
  endtask

  task automatic check_reg(input vec_pkg::vreg_idx_t r);
    int i;
    for (i = 0; i < vec_pkg::VLMAX; i++) begin
      read_elem(r, vec_pkg::elem_t'(i));
    end
  endtask

  // Shrinking splats leave a distinct random value in every element
  task automatic fill_random(input vec_pkg::vreg_idx_t r);
    int k;
    for (k = vec_pkg::VLMAX; k >= 1; k--) begin
      set_vl(vec_pkg::elem_t'(k));
      run_op(vec_pkg::VOP_MV, r, 3'd0, 3'd0, 1'b1, $urandom(), 1'b0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  // Idle handshake right after reset
  task automatic test_reset_state();
    check_eq(vec_pkg::elem_t'(req_ready_o), 32'd1, "req_ready_o after reset");
    check_eq(vec_pkg::elem_t'(resp_valid_o), 32'd0, "resp_valid_o after reset");
  endtask

  task automatic test_setvl();
    set_vl(32'd0);
    set_vl(32'd5);
    set_vl(32'd16);
    set_vl(32'd40);
  endtask

  task automatic test_alu_ops();
    vec_pkg::vop_e ops [5];
    int            o;
    int            us;
    ops = '{vec_pkg::VOP_ADD, vec_pkg::VOP_SUB, vec_pkg::VOP_AND,
            vec_pkg::VOP_OR, vec_pkg::VOP_XOR};
    fill_random(3'd1);
    fill_random(3'd2);
    set_vl(32'd16);
    for (us = 0; us < 2; us++) begin
      for (o = 0; o < 5; o++) begin
        run_op(ops[o], 3'd3, 3'd1, 3'd2, us[0], $urandom(), 1'b0);
        check_reg(3'd3);
      end
    end
    // Register copy
    run_op(vec_pkg::VOP_MV, 3'd4, 3'd2, 3'd0, 1'b0, '0, 1'b0);
    check_reg(3'd4);
  endtask

  task automatic test_tail_kept();
    set_vl(32'd6);
    run_op(vec_pkg::VOP_SUB, 3'd3, 3'd1, 3'd2, 1'b0, '0, 1'b0);
    check_reg(3'd3);
    run_op(vec_pkg::VOP_XOR, 3'd4, 3'd0, 3'd1, 1'b1, $urandom(), 1'b0);
    check_reg(3'd4);
  endtask

  task automatic test_redsum();
    int             lens [3];
    int             n;
    int             i;
    vec_pkg::elem_t s;
    vec_pkg::elem_t sum;
    lens = '{1, 7, 16};
    fill_random(3'd5);
    for (n = 0; n < 3; n++) begin
      set_vl(vec_pkg::elem_t'(lens[n]));
      s   = $urandom();
      sum = s;
      for (i = 0; i < lens[n]; i++) begin
        sum = sum + model_vrf[5][i];
      end
      send_insn(make_arith(vec_pkg::VOP_REDSUM, 3'd0, 3'd0, 3'd5, 1'b0), s, 1'b0);
      expect_resp(sum, $sformatf("redsum vl %0d", lens[n]));
    end
    // Out-of-range index reads back zero
    read_elem(3'd5, 32'd16);
    read_elem(3'd5, 32'd31);
    read_elem(3'd5, 32'hffff_ffff);
  endtask

  task automatic test_back_to_back();
    vec_pkg::elem_t exp_q[$];
    vec_pkg::elem_t s;
    vec_pkg::elem_t sum;
    int             i;
    int             stalls_before;
    set_vl(32'd16);
    run_op(vec_pkg::VOP_MV, 3'd6, 3'd5, 3'd0, 1'b0, '0, 1'b0);
    stalls_before = stalls;
    // Stream with valid held high from here on
    send_insn(make_cfg(), 32'd9, 1'b1);
    model_vl = 9;
    exp_q.push_back(32'd9);
    run_op(vec_pkg::VOP_ADD, 3'd6, 3'd1, 3'd2, 1'b0, '0, 1'b1);
    s   = $urandom();
    sum = s;
    for (i = 0; i < model_vl; i++) begin
      sum = sum + model_vrf[6][i];
    end
    send_insn(make_arith(vec_pkg::VOP_REDSUM, 3'd0, 3'd0, 3'd6, 1'b0), s, 1'b1);
    exp_q.push_back(sum);
    send_insn(make_arith(vec_pkg::VOP_EXTRACT, 3'd0, 3'd0, 3'd6, 1'b0), 32'd3, 1'b1);
    exp_q.push_back(model_vrf[6][3]);
    send_insn(make_arith(vec_pkg::VOP_EXTRACT, 3'd0, 3'd0, 3'd6, 1'b0), 32'd12, 1'b0);
    exp_q.push_back(model_vrf[6][12]);
    // Full dispatcher slot behind a busy add holds off the next request
    check_eq(vec_pkg::elem_t'(stalls > stalls_before), 32'd1,
             "req_ready_o low while lanes busy");
    while (exp_q.size() != 0) begin
      expect_resp(exp_q.pop_front(), "back-to-back response");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Run control
  ////////////////////////////////////////////////////////////

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= 200 * n_sent + 1000) begin
      @(posedge clk_i);
      cycles++;
    end
    errors++;
    $display("Timeout: run stalled after %0d cycles with %0d requests sent", cycles, n_sent);
    $display("Errors: %0d", errors);
    $display("** FAIL **");
    $finish;
  end

  initial begin : main
    int r;
    int e;
    void'($urandom(49));
    errors       = 0;
    n_sent       = 0;
    stalls       = 0;
    model_vl     = 0;
    rst_n_i      = 1'b0;
    req_valid_i  = 1'b0;
    req_insn_i   = '0;
    req_scalar_i = '0;
    for (r = 0; r < vec_pkg::NR_VREGS; r++) begin
      for (e = 0; e < vec_pkg::VLMAX; e++) begin
        model_vrf[r][e] = '0;
      end
    end
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    test_reset_state();
    test_setvl();
    test_alu_ops();
    test_tail_kept();
    test_redsum();
    test_back_to_back();

    repeat (20) @(posedge clk_i);
    check_eq(vec_pkg::elem_t'(resp_q.size()), '0, "unexpected extra responses");
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/vec_dispatcher.sv
`timescale 1ns/1ps
`default_nettype none

module vec_dispatcher (
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  // Core request
  input  wire logic              req_valid_i,
  input  vec_pkg::vinsn_u        req_insn_i,
  input  vec_pkg::elem_t         req_scalar_i,
  output logic                   req_ready_o,
  // Decoded instruction to the sequencer
  input  wire logic              dec_ready_i,
  output logic                   dec_valid_o,
  output vec_pkg::vop_e          dec_op_o,
  output vec_pkg::vreg_idx_t     dec_vd_o,
  output vec_pkg::vreg_idx_t     dec_vs1_o,
  output vec_pkg::vreg_idx_t     dec_vs2_o,
  output logic                   dec_use_scalar_o,
  output vec_pkg::elem_t         dec_scalar_o
);

  logic slot_valid_q;
  logic accept;

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////

  // Slot can be refilled in the cycle it drains
  assign req_ready_o = !slot_valid_q || dec_ready_i;
  assign accept      = req_valid_i && req_ready_o;
  assign dec_valid_o = slot_valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      slot_valid_q <= 1'b0;
    end else if (accept) begin
      slot_valid_q <= 1'b1;
    end else if (dec_ready_i) begin
      slot_valid_q <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Decode into the holding slot
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (accept) begin
      dec_scalar_o <= req_scalar_i;
      if (req_insn_i.cfg.fmt) begin
        // Config word carries no register fields
        dec_op_o         <= vec_pkg::VOP_SETVL;
        dec_vd_o         <= '0;
        dec_vs1_o        <= '0;
        dec_vs2_o        <= '0;
        dec_use_scalar_o <= 1'b0;
      end else begin
        dec_op_o         <= req_insn_i.arith.funct;
        dec_vd_o         <= req_insn_i.arith.vd;
        dec_vs1_o        <= req_insn_i.arith.vs1;
        dec_vs2_o        <= req_insn_i.arith.vs2;
        dec_use_scalar_o <= req_insn_i.arith.use_scalar;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/vec_lane.sv
`timescale 1ns/1ps
`default_nettype none

module vec_lane #(
  parameter int LANE_ID = 0
) (
  input  wire logic         clk_i,
  input  wire logic         rst_n_i,
  input  wire logic         issue_start_i,
  input  vec_pkg::vop_e     issue_op_i,
  input  vec_pkg::vreg_idx_t issue_vd_i,
  input  vec_pkg::vreg_idx_t issue_vs1_i,
  input  vec_pkg::vreg_idx_t issue_vs2_i,
  input  wire logic         issue_use_scalar_i,
  input  vec_pkg::elem_t    issue_scalar_i,
  input  vec_pkg::vl_t      issue_vl_i,
  output logic              lane_done_o,
  output vec_pkg::elem_t    lane_partial_o
);

  // Register file slice, rows of this lane only
  vec_pkg::elem_t vrf_q [vec_pkg::NR_VREGS][vec_pkg::ROWS_PER_LANE];

  logic                      active_q;
  logic                      done_q;
  logic [vec_pkg::ROW_W-1:0] row_q;
  vec_pkg::elem_t            partial_q;
  vec_pkg::vl_t              nrows;
  logic                      has_work;
  logic                      writes_vd;
  logic                      owns_idx;
  logic [vec_pkg::ROW_W-1:0] ext_row;
  vec_pkg::elem_t            opa;
  vec_pkg::elem_t            opb;
  vec_pkg::elem_t            alu_res;

  ////////////////////////////////////////////////////////////
  // Element bookkeeping
  ////////////////////////////////////////////////////////////

  // Count of indices below vl that map to this lane
  always_comb begin
    if (int'(issue_vl_i) > LANE_ID) begin
      nrows = vec_pkg::vl_t'((int'(issue_vl_i) - LANE_ID - 1) / vec_pkg::NR_LANES + 1);
    end else begin
      nrows = '0;
    end
  end

  assign has_work  = (issue_op_i != vec_pkg::VOP_EXTRACT) && (nrows != '0);
  assign writes_vd = issue_op_i inside {vec_pkg::VOP_ADD, vec_pkg::VOP_SUB, vec_pkg::VOP_AND,
                                        vec_pkg::VOP_OR, vec_pkg::VOP_XOR, vec_pkg::VOP_MV};

  // Extract index owner check
  assign owns_idx = (issue_scalar_i < vec_pkg::elem_t'(vec_pkg::VLMAX)) &&
                    (issue_scalar_i[vec_pkg::LANE_W-1:0] == vec_pkg::LANE_W'(LANE_ID));
  assign ext_row  = issue_scalar_i[vec_pkg::LANE_W +: vec_pkg::ROW_W];

  ////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////

  assign opa = issue_use_scalar_i ? issue_scalar_i : vrf_q[issue_vs1_i][row_q];
  assign opb = vrf_q[issue_vs2_i][row_q];

  always_comb begin
    case (issue_op_i)
      vec_pkg::VOP_ADD: alu_res = opb + opa;
      vec_pkg::VOP_SUB: alu_res = opb - opa;
      vec_pkg::VOP_AND: alu_res = opb & opa;
      vec_pkg::VOP_OR:  alu_res = opb | opa;
      vec_pkg::VOP_XOR: alu_res = opb ^ opa;
      default:          alu_res = opa;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < vec_pkg::NR_VREGS; r++) begin
        for (int c = 0; c < vec_pkg::ROWS_PER_LANE; c++) begin
          vrf_q[r][c] <= '0;
        end
      end
      active_q  <= 1'b0;
      done_q    <= 1'b0;
      row_q     <= '0;
      partial_q <= '0;
    end else if (issue_start_i) begin
      row_q     <= '0;
      active_q  <= has_work;
      done_q    <= !has_work;
      partial_q <= (issue_op_i == vec_pkg::VOP_EXTRACT && owns_idx) ?
                   vrf_q[issue_vs2_i][ext_row] : '0;
    end else if (active_q) begin
      if (writes_vd) begin
        vrf_q[issue_vd_i][row_q] <= alu_res;
      end
      // Reduction sums vs2
      if (issue_op_i == vec_pkg::VOP_REDSUM) begin
        partial_q <= partial_q + opb;
      end
      if (vec_pkg::vl_t'(row_q) == nrows - vec_pkg::vl_t'(1)) begin
        active_q <= 1'b0;
        done_q   <= 1'b1;
      end else begin
        row_q <= row_q + 1'b1;
      end
    end
  end

  assign lane_done_o    = done_q;
  assign lane_partial_o = partial_q;

endmodule

`default_nettype wire

// File: hdl/vec_pkg.sv
`default_nettype none

package vec_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  localparam int NR_LANES      = 4;
  localparam int ELEN          = 32;
  localparam int NR_VREGS      = 8;
  localparam int ROWS_PER_LANE = 4;
  localparam int VLMAX         = NR_LANES * ROWS_PER_LANE;
  localparam int VL_W          = $clog2(VLMAX + 1);
  // Element index split into lane and row fields
  localparam int LANE_W        = $clog2(NR_LANES);
  localparam int ROW_W         = $clog2(ROWS_PER_LANE);

  // Element i lives in lane (i mod NR_LANES) at row (i / NR_LANES)

  typedef logic [ELEN-1:0]                 elem_t;
  typedef logic [$clog2(NR_VREGS)-1:0]     vreg_idx_t;
  typedef logic [VL_W-1:0]                 vl_t;

  ////////////////////////////////////////////////////////////
  // Operations and instruction word
  ////////////////////////////////////////////////////////////

  typedef enum logic [5:0] {
    VOP_ADD     = 6'h00,
    VOP_SUB     = 6'h01,
    VOP_AND     = 6'h02,
    VOP_OR      = 6'h03,
    VOP_XOR     = 6'h04,
    VOP_MV      = 6'h05,
    VOP_REDSUM  = 6'h06,
    VOP_EXTRACT = 6'h07,
    VOP_SETVL   = 6'h08
  } vop_e;

  // Bit 31 selects the view: set for config, clear for arith
  typedef union packed {
    struct packed {
      logic        fmt;
      logic [30:0] rsvd;
    } cfg;
    struct packed {
      logic        fmt;
      vop_e        funct;
      vreg_idx_t   vd;
      vreg_idx_t   vs1;
      vreg_idx_t   vs2;
      logic        use_scalar;
      logic [14:0] rsvd;
    } arith;
  } vinsn_u;

endpackage

`default_nettype wire

// File: hdl/vec_scalar_result.sv
`timescale 1ns/1ps
`default_nettype none

module vec_scalar_result (
  input  wire logic                             clk_i,
  input  wire logic                             rst_n_i,
  input  wire logic                             finish_i,
  input  vec_pkg::vop_e                         finish_op_i,
  input  vec_pkg::elem_t                        finish_scalar_i,
  input  vec_pkg::elem_t [vec_pkg::NR_LANES-1:0] lane_partial_i,
  output logic                                  resp_valid_o,
  output vec_pkg::elem_t                        resp_data_o
);

  vec_pkg::elem_t red_sum;
  vec_pkg::elem_t ext_or;
  vec_pkg::elem_t resp_next;
  logic           has_resp;

  ////////////////////////////////////////////////////////////
  // Combine lane partials
  ////////////////////////////////////////////////////////////

  always_comb begin
    red_sum = finish_scalar_i;
    ext_or  = '0;
    for (int l = 0; l < vec_pkg::NR_LANES; l++) begin
      red_sum = red_sum + lane_partial_i[l];
      // Only the owning lane is nonzero
      ext_or  = ext_or | lane_partial_i[l];
    end
  end

  always_comb begin
    case (finish_op_i)
      vec_pkg::VOP_REDSUM:  resp_next = red_sum;
      vec_pkg::VOP_EXTRACT: resp_next = ext_or;
      default:              resp_next = finish_scalar_i;
    endcase
  end

  assign has_resp = finish_op_i inside {vec_pkg::VOP_REDSUM, vec_pkg::VOP_EXTRACT,
                                        vec_pkg::VOP_SETVL};

  // Single insn in flight, so responses leave in request order
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= finish_i && has_resp;
    end
  end

  always_ff @(posedge clk_i) begin
    if (finish_i) begin
      resp_data_o <= resp_next;
    end
  end

endmodule

`default_nettype wire

// File: hdl/vec_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module vec_sequencer (
  input  wire logic                         clk_i,
  input  wire logic                         rst_n_i,
  // From the dispatcher
  input  wire logic                         dec_valid_i,
  input  vec_pkg::vop_e                     dec_op_i,
  input  vec_pkg::vreg_idx_t                dec_vd_i,
  input  vec_pkg::vreg_idx_t                dec_vs1_i,
  input  vec_pkg::vreg_idx_t                dec_vs2_i,
  input  wire logic                         dec_use_scalar_i,
  input  vec_pkg::elem_t                    dec_scalar_i,
  output logic                              dec_ready_o,
  // Lanes
  input  wire logic [vec_pkg::NR_LANES-1:0] lane_done_i,
  output logic                              issue_start_o,
  output vec_pkg::vop_e                     issue_op_o,
  output vec_pkg::vreg_idx_t                issue_vd_o,
  output vec_pkg::vreg_idx_t                issue_vs1_o,
  output vec_pkg::vreg_idx_t                issue_vs2_o,
  output logic                              issue_use_scalar_o,
  output vec_pkg::elem_t                    issue_scalar_o,
  output vec_pkg::vl_t                      issue_vl_o,
  // Scalar-result unit
  output logic                              finish_o,
  output vec_pkg::vop_e                     finish_op_o,
  output vec_pkg::elem_t                    finish_scalar_o
);

  logic          busy_q;
  vec_pkg::vl_t  vl_q;
  vec_pkg::vl_t  setvl_val;
  logic          take;
  logic          is_setvl;
  logic          lanes_done;

  assign dec_ready_o = !busy_q;
  assign take        = dec_valid_i && !busy_q;
  assign is_setvl    = (dec_op_i == vec_pkg::VOP_SETVL);

  // Clamp requested length to VLMAX
  assign setvl_val = (dec_scalar_i > vec_pkg::elem_t'(vec_pkg::VLMAX)) ?
                     vec_pkg::vl_t'(vec_pkg::VLMAX) : vec_pkg::vl_t'(dec_scalar_i);

  // Done levels still show the previous insn during the issue cycle
  assign lanes_done = busy_q && !issue_start_o && (&lane_done_i);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q        <= 1'b0;
      issue_start_o <= 1'b0;
      finish_o      <= 1'b0;
      vl_q          <= '0;
    end else begin
      issue_start_o <= 1'b0;
      finish_o      <= 1'b0;
      if (take && is_setvl) begin
        // No lane work, respond right away
        vl_q     <= setvl_val;
        finish_o <= 1'b1;
      end else if (take) begin
        busy_q        <= 1'b1;
        issue_start_o <= 1'b1;
      end
      if (lanes_done) begin
        busy_q   <= 1'b0;
        finish_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take && !is_setvl) begin
      issue_op_o         <= dec_op_i;
      issue_vd_o         <= dec_vd_i;
      issue_vs1_o        <= dec_vs1_i;
      issue_vs2_o        <= dec_vs2_i;
      issue_use_scalar_o <= dec_use_scalar_i;
      issue_scalar_o     <= dec_scalar_i;
      issue_vl_o         <= vl_q;
    end
    if (take && is_setvl) begin
      finish_op_o     <= vec_pkg::VOP_SETVL;
      finish_scalar_o <= vec_pkg::elem_t'(setvl_val);
    end else if (lanes_done) begin
      finish_op_o     <= issue_op_o;
      finish_scalar_o <= issue_scalar_o;
    end
  end

endmodule

`default_nettype wire

// File: hdl/vec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module vec_unit (
  input  wire logic      clk_i,
  input  wire logic      rst_n_i,
  // Core request
  input  wire logic      req_valid_i,
  input  vec_pkg::vinsn_u req_insn_i,
  input  vec_pkg::elem_t req_scalar_i,
  output logic           req_ready_o,
  // Core response
  output logic           resp_valid_o,
  output vec_pkg::elem_t resp_data_o
);

  ////////////////////////////////////////////////////////////
  // Dispatcher
  ////////////////////////////////////////////////////////////

  logic               dec_valid;
  logic               dec_ready;
  vec_pkg::vop_e      dec_op;
  vec_pkg::vreg_idx_t dec_vd;
  vec_pkg::vreg_idx_t dec_vs1;
  vec_pkg::vreg_idx_t dec_vs2;
  logic               dec_use_scalar;
  vec_pkg::elem_t     dec_scalar;

  vec_dispatcher u_dispatcher (
    .clk_i            (clk_i          ),
    .rst_n_i          (rst_n_i        ),
    .req_valid_i      (req_valid_i    ),
    .req_insn_i       (req_insn_i     ),
    .req_scalar_i     (req_scalar_i   ),
    .req_ready_o      (req_ready_o    ),
    .dec_ready_i      (dec_ready      ),
    .dec_valid_o      (dec_valid      ),
    .dec_op_o         (dec_op         ),
    .dec_vd_o         (dec_vd         ),
    .dec_vs1_o        (dec_vs1        ),
    .dec_vs2_o        (dec_vs2        ),
    .dec_use_scalar_o (dec_use_scalar ),
    .dec_scalar_o     (dec_scalar     )
  );

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  logic [vec_pkg::NR_LANES-1:0]          lane_done;
  vec_pkg::elem_t [vec_pkg::NR_LANES-1:0] lane_partial;
  logic               issue_start;
  vec_pkg::vop_e      issue_op;
  vec_pkg::vreg_idx_t issue_vd;
  vec_pkg::vreg_idx_t issue_vs1;
  vec_pkg::vreg_idx_t issue_vs2;
  logic               issue_use_scalar;
  vec_pkg::elem_t     issue_scalar;
  vec_pkg::vl_t       issue_vl;
  logic               finish;
  vec_pkg::vop_e      finish_op;
  vec_pkg::elem_t     finish_scalar;

  vec_sequencer u_sequencer (
    .clk_i              (clk_i           ),
    .rst_n_i            (rst_n_i         ),
    .dec_valid_i        (dec_valid       ),
    .dec_op_i           (dec_op          ),
    .dec_vd_i           (dec_vd          ),
    .dec_vs1_i          (dec_vs1         ),
    .dec_vs2_i          (dec_vs2         ),
    .dec_use_scalar_i   (dec_use_scalar  ),
    .dec_scalar_i       (dec_scalar      ),
    .dec_ready_o        (dec_ready       ),
    .lane_done_i        (lane_done       ),
    .issue_start_o      (issue_start     ),
    .issue_op_o         (issue_op        ),
    .issue_vd_o         (issue_vd        ),
    .issue_vs1_o        (issue_vs1       ),
    .issue_vs2_o        (issue_vs2       ),
    .issue_use_scalar_o (issue_use_scalar),
    .issue_scalar_o     (issue_scalar    ),
    .issue_vl_o         (issue_vl        ),
    .finish_o           (finish          ),
    .finish_op_o        (finish_op       ),
    .finish_scalar_o    (finish_scalar   )
  );

  ////////////////////////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////////////////////////

  for (genvar l = 0; l < vec_pkg::NR_LANES; l++) begin : gen_lanes
    vec_lane #(
      .LANE_ID (l)
    ) u_lane (
      .clk_i              (clk_i           ),
      .rst_n_i            (rst_n_i         ),
      .issue_start_i      (issue_start     ),
      .issue_op_i         (issue_op        ),
      .issue_vd_i         (issue_vd        ),
      .issue_vs1_i        (issue_vs1       ),
      .issue_vs2_i        (issue_vs2       ),
      .issue_use_scalar_i (issue_use_scalar),
      .issue_scalar_i     (issue_scalar    ),
      .issue_vl_i         (issue_vl        ),
      .lane_done_o        (lane_done[l]    ),
      .lane_partial_o     (lane_partial[l] )
    );
  end : gen_lanes

  ////////////////////////////////////////////////////////////
  // Scalar result
  ////////////////////////////////////////////////////////////

  vec_scalar_result u_scalar_result (
    .clk_i           (clk_i        ),
    .rst_n_i         (rst_n_i      ),
    .finish_i        (finish       ),
    .finish_op_i     (finish_op    ),
    .finish_scalar_i (finish_scalar),
    .lane_partial_i  (lane_partial ),
    .resp_valid_o    (resp_valid_o ),
    .resp_data_o     (resp_data_o  )
  );

endmodule

`default_nettype wire
